// ==== compile.f ====
hw/mm_pkg.sv
hw/mat_buffer.sv
hw/mm_pe.sv
hw/mm_engine.sv
hw/dma_engine.sv
hw/mm_accel_top.sv
testbench/axi_mem_model.sv
testbench/tb_mm_accel.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the matrix-multiply accelerator testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_mm_accel \
    --Mdir obj_dir -o sim_tb_mm_accel
./obj_dir/sim_tb_mm_accel | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

// ==== testbench/tb_mm_accel.sv ====
// ----------------------------------------
// tb_mm_accel
// random matrix jobs against a reference
// product, with busy and back-to-back starts
// ----------------------------------------
`timescale 1ns/1ps

module tb_mm_accel;

    localparam int          sa       = 4;
    localparam int          n_elem   = sa * sa;
    localparam int          n_jobs   = 20;
    localparam int          n_slots  = 256;
    localparam logic [31:0] tb_seed  = 32'hd85eff8c;
    localparam mm_pkg::burst_len_t exp_len = mm_pkg::burst_len_t'(n_elem - 1);

    logic            clk;
    logic            rst_n;
    mm_pkg::addr_t   a_addr;
    mm_pkg::addr_t   b_addr;
    mm_pkg::addr_t   c_addr;
    logic            start;
    logic            done_o;
    mm_pkg::ar_req_t ar;
    logic            arready;
    mm_pkg::r_beat_t r;
    logic            rready;
    mm_pkg::aw_req_t aw;
    logic            awready;
    mm_pkg::w_beat_t w;
    logic            wready;
    mm_pkg::b_resp_t b;
    logic            bready;

    integer seed;
    int     n_checks = 0;
    int     n_errors = 0;
    int     n_tests  = 0;
    int     done_cnt = 0;
    logic   b_seen   = 1'b0;

    mm_pkg::word_t ma [sa][sa];
    mm_pkg::word_t mb [sa][sa];
    mm_pkg::word_t mc [sa][sa];

    mm_accel_top #(.sa_width(sa)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_addr_i  (a_addr),
        .b_addr_i  (b_addr),
        .c_addr_i  (c_addr),
        .start_i   (start),
        .done_o    (done_o),
        .ar_o      (ar),
        .arready_i (arready),
        .r_i       (r),
        .rready_o  (rready),
        .aw_o      (aw),
        .awready_i (awready),
        .w_o       (w),
        .wready_i  (wready),
        .b_i       (b),
        .bready_o  (bready)
    );

    axi_mem_model #(.mem_words(n_slots * n_elem), .seed_init(tb_seed)) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_i      (ar),
        .arready_o (arready),
        .r_o       (r),
        .rready_i  (rready),
        .aw_i      (aw),
        .awready_o (awready),
        .w_i       (w),
        .wready_o  (wready),
        .b_o       (b),
        .bready_i  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // done_o has to follow an accepted write response by one cycle
    always @(posedge clk) begin
        if (rst_n && done_o) begin
            done_cnt = done_cnt + 1;
            if (!b_seen) begin
                n_errors = n_errors + 1;
                $display("[ERROR] %0t: done_o pulsed with no write response before it", $time);
            end
        end
        b_seen <= rst_n && b.valid && bready;
    end

    initial begin
        repeat (n_jobs * 2000) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", n_jobs * 2000);
        $display("tests failed");
        $finish;
    end

    task automatic check_word(input mm_pkg::word_t got, input mm_pkg::word_t exp,
                              input string what);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input mm_pkg::addr_t got, input mm_pkg::addr_t exp,
                              input string what);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input mm_pkg::burst_len_t got, input mm_pkg::burst_len_t exp,
                             input string what);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input mm_pkg::axi_id_t got, input mm_pkg::axi_id_t exp,
                            input string what);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report(input string name, input int err0);
        n_tests = n_tests + 1;
        if (n_errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, n_errors - err0);
        end
    endtask

    function automatic int pick_slot();
        return int'($random(seed) & 32'hff);
    endfunction

    // random A and B into memory, C as wrapped 32-bit dot products
    task automatic load_matrices(input int a_base, input int b_base);
        mm_pkg::word_t sum;
        for (int i = 0; i < sa; i++) begin
            for (int k = 0; k < sa; k++) begin
                ma[i][k] = $random(seed);
                mb[i][k] = $random(seed);
                u_mem.mem[a_base + k * sa + i] = ma[i][k];
                u_mem.mem[b_base + i * sa + k] = mb[i][k];
            end
        end
        for (int i = 0; i < sa; i++) begin
            for (int j = 0; j < sa; j++) begin
                sum = '0;
                for (int k = 0; k < sa; k++) begin
                    sum = sum + ma[i][k] * mb[k][j];
                end
                mc[i][j] = sum;
            end
        end
    endtask

    task automatic run_job(input int job, input bit busy);
        int              err0;
        int              ar0;
        int              aw0;
        int              w0;
        int              slot_a;
        int              slot_b;
        int              slot_c;
        mm_pkg::addr_t   a;
        mm_pkg::addr_t   bb;
        mm_pkg::addr_t   c;
        mm_pkg::ar_req_t req;
        mm_pkg::aw_req_t wreq;
        mm_pkg::w_beat_t beat;
        err0 = n_errors;
        ar0  = u_mem.ar_log.size();
        aw0  = u_mem.aw_log.size();
        w0   = u_mem.w_log.size();
        slot_a = pick_slot();
        do begin
            slot_b = pick_slot();
        end while (slot_b == slot_a);
        do begin
            slot_c = pick_slot();
        end while (slot_c == slot_a || slot_c == slot_b);
        a  = mm_pkg::addr_t'(slot_a * n_elem * 4);
        bb = mm_pkg::addr_t'(slot_b * n_elem * 4);
        c  = mm_pkg::addr_t'(slot_c * n_elem * 4);
        load_matrices(slot_a * n_elem, slot_b * n_elem);

        @(posedge clk);
        a_addr <= a;
        b_addr <= bb;
        c_addr <= c;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (busy) begin
            repeat (6) @(posedge clk);
            // swapped addresses, must not reach the job
            a_addr <= c;
            c_addr <= a;
            start  <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        do begin
            @(negedge clk);
        end while (!done_o);

        // the pulse seen now is counted on the coming edge
        if (done_cnt != job) begin
            n_errors = n_errors + 1;
            $display("job %0d: done_o pulsed %0d times before this job ended", job, done_cnt);
        end
        if (u_mem.ar_log.size() - ar0 != 2) begin
            n_errors = n_errors + 1;
            $display("job %0d: %0d read requests instead of 2", job, u_mem.ar_log.size() - ar0);
        end else begin
            req = u_mem.ar_log[ar0];
            check_id(req.id, 1'b0, "first read id");
            check_addr(req.addr, a, "first read address");
            check_len(req.len, exp_len, "first read length");
            req = u_mem.ar_log[ar0 + 1];
            check_id(req.id, 1'b1, "second read id");
            check_addr(req.addr, bb, "second read address");
            check_len(req.len, exp_len, "second read length");
        end
        if (u_mem.aw_log.size() - aw0 != 1 || u_mem.w_log.size() - w0 != n_elem) begin
            n_errors = n_errors + 1;
            $display("job %0d: write burst has the wrong number of requests or beats", job);
        end else begin
            wreq = u_mem.aw_log[aw0];
            check_addr(wreq.addr, c, "write address");
            check_len(wreq.len, exp_len, "write length");
            for (int e = 0; e < n_elem; e++) begin
                beat = u_mem.w_log[w0 + e];
                check_word(beat.data, mc[e / sa][e % sa], $sformatf("job %0d C[%0d]", job, e));
                check_flag(beat.last, e == n_elem - 1, $sformatf("job %0d wlast %0d", job, e));
            end
        end
        report($sformatf("job %0d%s", job, busy ? " with busy start" : ""), err0);
    endtask

    initial begin
        int err0;
        seed   = tb_seed;
        rst_n  = 1'b0;
        start  = 1'b0;
        a_addr = '0;
        b_addr = '0;
        c_addr = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        err0 = n_errors;
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(ar.valid, 1'b0, "ar valid after reset");
        check_flag(aw.valid, 1'b0, "aw valid after reset");
        check_flag(w.valid, 1'b0, "w valid after reset");
        check_flag(rready, 1'b0, "rready after reset");
        check_flag(bready, 1'b0, "bready after reset");
        report("reset values", err0);

        // each job starts on the edge after the previous done_o
        for (int j = 0; j < n_jobs; j++) begin
            run_job(j, (j % 4) == 3);
        end

        err0 = n_errors;
        repeat (50) @(negedge clk);
        if (done_cnt != n_jobs || u_mem.ar_log.size() != 2 * n_jobs) begin
            n_errors = n_errors + 1;
            $display("idle check: %0d done pulses and %0d read requests for %0d jobs",
                     done_cnt, u_mem.ar_log.size(), n_jobs);
        end
        report("idle after jobs", err0);

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/axi_mem_model.sv ====
// ----------------------------------------
// axi_mem_model
// word memory serving read and write bursts
// with random ready/valid delays
// ----------------------------------------
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          mem_words = 4096,
    parameter logic [31:0] seed_init = 32'h1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mm_pkg::ar_req_t ar_i,
    output logic            arready_o,
    output mm_pkg::r_beat_t r_o,
    input  logic            rready_i,
    input  mm_pkg::aw_req_t aw_i,
    output logic            awready_o,
    input  mm_pkg::w_beat_t w_i,
    output logic            wready_o,
    output mm_pkg::b_resp_t b_o,
    input  logic            bready_i
);

    mm_pkg::word_t   mem [mem_words];
    mm_pkg::ar_req_t ar_log [$];
    mm_pkg::aw_req_t aw_log [$];
    mm_pkg::w_beat_t w_log [$];

    // read bursts still to be served, oldest first
    mm_pkg::ar_req_t rd_q [$];

    integer seed;
    int     r_beat;
    int     w_base;
    int     w_cnt;
    logic   b_pend;

    function automatic int widx(input mm_pkg::addr_t a);
        return int'(a[31:2]) % mem_words;
    endfunction

    // high three times out of four
    function automatic logic coin();
        return ($random(seed) & 3) != 0;
    endfunction

    initial begin
        seed = seed_init;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = mm_pkg::word_t'(i) * 32'h9e37_79b1;
        end
    end

    always @(posedge clk) begin : serve
        logic r_take;
        if (!rst_n) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            r_o       <= '0;
            b_o       <= '0;
            r_beat = 0;
            w_base = 0;
            w_cnt  = 0;
            b_pend = 1'b0;
            rd_q.delete();
        end else begin
            if (ar_i.valid && arready_o) begin
                rd_q.push_back(ar_i);
                ar_log.push_back(ar_i);
            end
            arready_o <= coin();

            r_take = r_o.valid && rready_i;
            if (r_take) begin
                if (r_o.last) begin
                    void'(rd_q.pop_front());
                    r_beat = 0;
                end else begin
                    r_beat = r_beat + 1;
                end
            end
            // a beat on offer stays put until it is taken
            if (!r_o.valid || r_take) begin
                if (rd_q.size() > 0 && coin()) begin
                    r_o <= '{
                        valid: 1'b1,
                        id:    rd_q[0].id,
                        data:  mem[widx(rd_q[0].addr) + r_beat],
                        last:  r_beat == int'(rd_q[0].len)
                    };
                end else begin
                    r_o <= '0;
                end
            end

            if (aw_i.valid && awready_o) begin
                aw_log.push_back(aw_i);
                w_base = widx(aw_i.addr);
                w_cnt  = 0;
            end
            awready_o <= coin();

            if (w_i.valid && wready_o) begin
                mem[w_base + w_cnt] = w_i.data;
                w_log.push_back(w_i);
                w_cnt = w_cnt + 1;
                if (w_i.last) begin
                    b_pend = 1'b1;
                end
            end
            wready_o <= coin();

            if (b_o.valid && bready_i) begin
                b_o <= '0;
            end else if (b_pend && !b_o.valid && coin()) begin
                b_o <= '{valid: 1'b1, resp: 2'b00};
                b_pend = 1'b0;
            end
        end
    end

endmodule

// ==== hw/mm_accel_top.sv ====
// ----------------------------------------
// mm_accel_top
// DMA engine, A/B line buffers and the
// systolic array engine
// ----------------------------------------
`timescale 1ns/1ps

module mm_accel_top #(
    parameter int sa_width = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mm_pkg::addr_t   a_addr_i,
    input  mm_pkg::addr_t   b_addr_i,
    input  mm_pkg::addr_t   c_addr_i,
    input  logic            start_i,
    output logic            done_o,
    output mm_pkg::ar_req_t ar_o,
    input  logic            arready_i,
    input  mm_pkg::r_beat_t r_i,
    output logic            rready_o,
    output mm_pkg::aw_req_t aw_o,
    input  logic            awready_i,
    output mm_pkg::w_beat_t w_o,
    input  logic            wready_i,
    input  mm_pkg::b_resp_t b_i,
    output logic            bready_o
);

    localparam int buf_aw = $clog2(sa_width);

    logic                         buf_a_wren;
    logic [buf_aw-1:0]            buf_a_waddr;
    mm_pkg::word_t [sa_width-1:0] buf_a_wdata;
    logic [buf_aw-1:0]            buf_a_raddr;
    mm_pkg::word_t [sa_width-1:0] buf_a_rdata;

    logic                         buf_b_wren;
    logic [buf_aw-1:0]            buf_b_waddr;
    mm_pkg::word_t [sa_width-1:0] buf_b_wdata;
    logic [buf_aw-1:0]            buf_b_raddr;
    mm_pkg::word_t [sa_width-1:0] buf_b_rdata;

    logic                                  mm_start;
    logic                                  mm_done;
    mm_pkg::word_t [sa_width*sa_width-1:0] accum;

    dma_engine #(.sa_width(sa_width)) u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .a_addr_i      (a_addr_i),
        .b_addr_i      (b_addr_i),
        .c_addr_i      (c_addr_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .ar_o          (ar_o),
        .arready_i     (arready_i),
        .r_i           (r_i),
        .rready_o      (rready_o),
        .aw_o          (aw_o),
        .awready_i     (awready_i),
        .w_o           (w_o),
        .wready_i      (wready_i),
        .b_i           (b_i),
        .bready_o      (bready_o),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    // A lines are columns of A, B lines are rows of B
    mat_buffer #(.sa_width(sa_width)) u_buf_a (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_a_waddr),
        .wdata_i (buf_a_wdata),
        .raddr_i (buf_a_raddr),
        .rdata_o (buf_a_rdata)
    );

    mat_buffer #(.sa_width(sa_width)) u_buf_b (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_b_waddr),
        .wdata_i (buf_b_wdata),
        .raddr_i (buf_b_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine #(.sa_width(sa_width)) u_mm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .done_o    (mm_done),
        .a_raddr_o (buf_a_raddr),
        .a_rdata_i (buf_a_rdata),
        .b_raddr_o (buf_b_raddr),
        .b_rdata_i (buf_b_rdata),
        .accum_o   (accum)
    );

endmodule

// ==== hw/dma_engine.sv ====
// ----------------------------------------
// dma_engine
// reads A and B, fills the line buffers,
// runs the array and writes C back
// ----------------------------------------
`timescale 1ns/1ps

module dma_engine #(
    parameter int sa_width = 4,
    localparam int buf_aw = $clog2(sa_width)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  mm_pkg::addr_t                         a_addr_i,
    input  mm_pkg::addr_t                         b_addr_i,
    input  mm_pkg::addr_t                         c_addr_i,
    input  logic                                  start_i,
    output logic                                  done_o,
    output mm_pkg::ar_req_t                       ar_o,
    input  logic                                  arready_i,
    input  mm_pkg::r_beat_t                       r_i,
    output logic                                  rready_o,
    output mm_pkg::aw_req_t                       aw_o,
    input  logic                                  awready_i,
    output mm_pkg::w_beat_t                       w_o,
    input  logic                                  wready_i,
    input  mm_pkg::b_resp_t                       b_i,
    output logic                                  bready_o,
    output logic                                  buf_a_wren_o,
    output logic [buf_aw-1:0]                     buf_a_waddr_o,
    output mm_pkg::word_t [sa_width-1:0]          buf_a_wdata_o,
    output logic                                  buf_b_wren_o,
    output logic [buf_aw-1:0]                     buf_b_waddr_o,
    output mm_pkg::word_t [sa_width-1:0]          buf_b_wdata_o,
    output logic                                  mm_start_o,
    input  logic                                  mm_done_i,
    input  mm_pkg::word_t [sa_width*sa_width-1:0] accum_i
);

    typedef mm_pkg::word_t [sa_width-1:0] line_t;

    typedef enum logic [2:0] {
        st_idle,
        st_addr_a,
        st_addr_b,
        st_load,
        st_wait_mm,
        st_addr_c,
        st_write_c,
        st_wait_b
    } state_t;

    localparam int n_elem = sa_width * sa_width;
    localparam int rx_w = $clog2(2 * n_elem);
    localparam int wc_w = $clog2(n_elem);
    localparam mm_pkg::burst_len_t burst_len = mm_pkg::burst_len_t'(n_elem - 1);

    state_t state;
    state_t state_nxt;

    mm_pkg::addr_t a_addr_q;
    mm_pkg::addr_t b_addr_q;
    mm_pkg::addr_t c_addr_q;

    // per-id packing state, indexed by the read id
    line_t             line_sr  [2];
    logic [buf_aw-1:0] word_cnt [2];
    logic [buf_aw-1:0] line_cnt [2];
    logic              buf_wren [2];

    logic [rx_w-1:0] rx_cnt;
    logic [wc_w-1:0] wr_cnt;
    logic            last_wr;

    logic r_fire;
    logic r_final;
    logic w_fire;
    logic b_fire;

    assign r_fire  = r_i.valid && rready_o;
    assign r_final = r_fire && (rx_cnt == rx_w'(2 * n_elem - 1));
    assign w_fire  = w_o.valid && wready_i;
    assign b_fire  = b_i.valid && bready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (start_i) state_nxt = st_addr_a;
            st_addr_a:  if (arready_i) state_nxt = st_addr_b;
            st_addr_b:  if (arready_i) state_nxt = st_load;
            st_load:    if (r_final) state_nxt = st_wait_mm;
            st_wait_mm: if (mm_done_i) state_nxt = st_addr_c;
            st_addr_c:  if (awready_i) state_nxt = st_write_c;
            st_write_c: if (w_fire && w_o.last) state_nxt = st_wait_b;
            st_wait_b:  if (b_fire) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    // job addresses held for the whole job
    always_ff @(posedge clk) begin
        if (state == st_idle && start_i) begin
            a_addr_q <= a_addr_i;
            b_addr_q <= b_addr_i;
            c_addr_q <= c_addr_i;
        end
    end

    // beats shift in from the top, first beat ends up in word 0
    always_ff @(posedge clk) begin
        if (r_fire) begin
            line_sr[r_i.id] <= {r_i.data, line_sr[r_i.id][sa_width-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt   <= '{default: '0};
            line_cnt   <= '{default: '0};
            buf_wren   <= '{default: 1'b0};
            rx_cnt     <= '0;
            wr_cnt     <= '0;
            last_wr    <= 1'b0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            buf_wren   <= '{default: 1'b0};
            last_wr    <= r_final;
            mm_start_o <= last_wr;
            done_o     <= b_fire;
            if (r_fire) begin
                rx_cnt <= rx_cnt + 1'b1;
                if (word_cnt[r_i.id] == buf_aw'(sa_width - 1)) begin
                    word_cnt[r_i.id] <= '0;
                    buf_wren[r_i.id] <= 1'b1;
                end else begin
                    word_cnt[r_i.id] <= word_cnt[r_i.id] + 1'b1;
                end
            end
            // next line after each buffer write
            for (int i = 0; i < 2; i++) begin
                if (buf_wren[i]) begin
                    line_cnt[i] <= line_cnt[i] + 1'b1;
                end
            end
            if (w_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    assign ar_o = '{
        valid: (state == st_addr_a) || (state == st_addr_b),
        id:    mm_pkg::axi_id_t'(state == st_addr_b),
        addr:  (state == st_addr_b) ? b_addr_q : a_addr_q,
        len:   burst_len
    };

    // B beats may follow A closely, so accept from the B request on
    assign rready_o = (state == st_addr_b) || (state == st_load);

    assign aw_o = '{valid: state == st_addr_c, addr: c_addr_q, len: burst_len};

    assign w_o = '{
        valid: state == st_write_c,
        data:  accum_i[wr_cnt],
        last:  wr_cnt == wc_w'(n_elem - 1)
    };

    assign bready_o = (state == st_wait_b);

    assign buf_a_wren_o  = buf_wren[0];
    assign buf_a_waddr_o = line_cnt[0];
    assign buf_a_wdata_o = line_sr[0];
    assign buf_b_wren_o  = buf_wren[1];
    assign buf_b_waddr_o = line_cnt[1];
    assign buf_b_wdata_o = line_sr[1];

endmodule

// ==== hw/mm_engine.sv ====
// ----------------------------------------
// mm_engine
// streams buffer lines through a skewed
// sa_width x sa_width PE grid
// ----------------------------------------
`timescale 1ns/1ps

module mm_engine #(
    parameter int sa_width = 4,
    localparam int buf_aw = $clog2(sa_width)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_i,
    output logic                                  done_o,
    output logic [buf_aw-1:0]                     a_raddr_o,
    input  mm_pkg::word_t [sa_width-1:0]          a_rdata_i,
    output logic [buf_aw-1:0]                     b_raddr_o,
    input  mm_pkg::word_t [sa_width-1:0]          b_rdata_i,
    output mm_pkg::word_t [sa_width*sa_width-1:0] accum_o
);

    typedef mm_pkg::word_t [sa_width-1:0] line_t;

    // last product lands in the far corner after 3*sa_width cycles
    localparam int last_cnt = 3 * sa_width - 1;
    localparam int cnt_w = $clog2(3 * sa_width);

    logic             run;
    logic [cnt_w-1:0] cnt;
    logic             rd_vld;
    logic             clear;
    line_t            a_line;
    line_t            b_line;

    mm_pkg::word_t a_h [sa_width][sa_width+1];
    mm_pkg::word_t b_v [sa_width+1][sa_width];
    mm_pkg::acc_t  acc [sa_width][sa_width];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run    <= 1'b0;
            cnt    <= '0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= run && (cnt < cnt_w'(sa_width));
            if (start_i) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (done_o) begin
                run <= 1'b0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign clear  = run && (cnt == '0);
    assign done_o = run && (cnt == cnt_w'(last_cnt));

    // line k read on count k, only the low bits matter while reading
    assign a_raddr_o = cnt[buf_aw-1:0];
    assign b_raddr_o = cnt[buf_aw-1:0];

    // zeros once the lines run out
    assign a_line = rd_vld ? a_rdata_i : '0;
    assign b_line = rd_vld ? b_rdata_i : '0;

    // row i of A and column i of B are delayed by i cycles
    for (genvar i = 0; i < sa_width; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_h[i][0] = a_line[i];
            assign b_v[0][i] = b_line[i];
        end else begin : g_delay
            mm_pkg::word_t [i-1:0] a_sr;
            mm_pkg::word_t [i-1:0] b_sr;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    a_sr <= '0;
                    b_sr <= '0;
                end else begin
                    a_sr[0] <= a_line[i];
                    b_sr[0] <= b_line[i];
                    for (int d = 1; d < i; d++) begin
                        a_sr[d] <= a_sr[d-1];
                        b_sr[d] <= b_sr[d-1];
                    end
                end
            end

            assign a_h[i][0] = a_sr[i-1];
            assign b_v[0][i] = b_sr[i-1];
        end
    end

    for (genvar i = 0; i < sa_width; i++) begin : g_row
        for (genvar j = 0; j < sa_width; j++) begin : g_col
            mm_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (clear),
                .a_i     (a_h[i][j]),
                .b_i     (b_v[i][j]),
                .a_o     (a_h[i][j+1]),
                .b_o     (b_v[i+1][j]),
                .acc_o   (acc[i][j])
            );

            // row-major, low word of each accumulator
            assign accum_o[i*sa_width+j] = acc[i][j][$bits(mm_pkg::word_t)-1:0];
        end
    end

endmodule

// ==== hw/mm_pe.sv ====
// ----------------------------------------
// mm_pe
// output-stationary MAC cell, passes A
// right and B down
// ----------------------------------------
`timescale 1ns/1ps

module mm_pe (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear_i,
    input  mm_pkg::word_t a_i,
    input  mm_pkg::word_t b_i,
    output mm_pkg::word_t a_o,
    output mm_pkg::word_t b_o,
    output mm_pkg::acc_t  acc_o
);

    logic signed [2*$bits(mm_pkg::word_t)-1:0] prod;

    // full-width signed product
    assign prod = $signed(a_i) * $signed(b_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
            if (clear_i) begin
                acc_o <= '0;
            end else begin
                acc_o <= acc_o + mm_pkg::acc_t'(prod);
            end
        end
    end

endmodule

// ==== hw/mat_buffer.sv ====
// ----------------------------------------
// mat_buffer
// sa_width lines, one write port and
// one registered read port
// ----------------------------------------
`timescale 1ns/1ps

module mat_buffer #(
    parameter int sa_width = 4,
    localparam int buf_aw = $clog2(sa_width)
) (
    input  logic                         clk,
    input  logic                         wren_i,
    input  logic [buf_aw-1:0]            waddr_i,
    input  mm_pkg::word_t [sa_width-1:0] wdata_i,
    input  logic [buf_aw-1:0]            raddr_i,
    output mm_pkg::word_t [sa_width-1:0] rdata_o
);

    typedef mm_pkg::word_t [sa_width-1:0] line_t;

    line_t mem [sa_width];

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // read data one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule

// ==== hw/mm_pkg.sv ====
// ----------------------------------------
// mm_pkg
// element, address and accumulator types
// plus the memory-channel payload structs
// ----------------------------------------
package mm_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic signed [64:0] acc_t;

    // 0 selects matrix A, 1 selects matrix B
    typedef logic axi_id_t;

    // beats minus one
    typedef logic [7:0] burst_len_t;

    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        addr_t      addr;
        burst_len_t len;
    } ar_req_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
        word_t   data;
        logic    last;
    } r_beat_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        burst_len_t len;
    } aw_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } b_resp_t;

endpackage
